// File: build.f
+incdir+testbench
hdl/ringRouterPkg.sv
hdl/packetSlot.sv
hdl/rotatingArbiter.sv
hdl/inputPort.sv
hdl/outputPort.sv
hdl/switchFabric.sv
hdl/ringRouter.sv
testbench/ringRouterTb.sv

// File: hdl/inputPort.sv
`timescale 1ns/1ps

module inputPort #(
    parameter bit isPePort = 1'b0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  polarity,
    input  ringRouterPkg::linkT   link,
    output logic                  ready,
    input  logic                  take,
    output ringRouterPkg::packetT packet,
    output logic                  full,
    output ringRouterPkg::routeT  route
);

    localparam int NUM_VC = ringRouterPkg::NUM_VC;

    logic [NUM_VC-1:0]     slotWr;
    logic [NUM_VC-1:0]     slotRd;
    logic [NUM_VC-1:0]     slotFull;
    logic [NUM_VC-1:0]     slotEmpty;
    ringRouterPkg::packetT slotData [NUM_VC];
    logic                  extVc;
    logic                  intVc;

    assign extVc = ~polarity;             // link side uses vc1 while polarity is 0
    assign intVc = polarity;              // fabric side uses the other one

    assign ready = slotEmpty[extVc];

    for (genvar v = 0; v < NUM_VC; v++) begin : gSlot
        assign slotWr[v] = link.send && ready && (extVc == 1'(v));
        assign slotRd[v] = take && (intVc == 1'(v));

        packetSlot uSlot (
            .clk      (clk),
            .reset    (reset),
            .wrEnable (slotWr[v]),
            .rdEnable (slotRd[v]),
            .dataIn   (link.packet),
            .dataOut  (slotData[v]),
            .full     (slotFull[v]),
            .empty    (slotEmpty[v])
        );
    end

    assign packet = slotData[intVc];
    assign full   = slotFull[intVc];

    // Route decode for the slot the fabric sees. A ring packet keeps going
    // while its hop lsb is set, otherwise it drops to the local pe. A pe
    // packet always enters the ring; dir picks the side in the fabric.
    always_comb begin
        if (isPePort) begin
            route.toRing = 1'b1;
            route.toPe   = 1'b0;          // no loopback to the own pe
        end else begin
            route.toRing = packet.hop[0];
            route.toPe   = ~packet.hop[0];
        end
    end

endmodule

// File: hdl/outputPort.sv
`timescale 1ns/1ps

module outputPort (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  polarity,
    input  logic                  load,
    input  ringRouterPkg::packetT packet,
    output logic                  empty,
    input  logic                  ready,
    output ringRouterPkg::linkT   link
);

    localparam int NUM_VC = ringRouterPkg::NUM_VC;

    logic [NUM_VC-1:0]     slotWr;
    logic [NUM_VC-1:0]     slotRd;
    logic [NUM_VC-1:0]     slotFull;
    logic [NUM_VC-1:0]     slotEmpty;
    ringRouterPkg::packetT slotData [NUM_VC];
    logic                  extVc;
    logic                  intVc;

    assign extVc = ~polarity;
    assign intVc = polarity;

    for (genvar v = 0; v < NUM_VC; v++) begin : gSlot
        assign slotWr[v] = load && (intVc == 1'(v));      // fabric fills internal vc
        assign slotRd[v] = link.send && (extVc == 1'(v)); // send already holds ready

        packetSlot uSlot (
            .clk      (clk),
            .reset    (reset),
            .wrEnable (slotWr[v]),
            .rdEnable (slotRd[v]),
            .dataIn   (packet),
            .dataOut  (slotData[v]),
            .full     (slotFull[v]),
            .empty    (slotEmpty[v])
        );
    end

    assign empty = slotEmpty[intVc];

    // handshake completes in the cycle send is high
    assign link.send   = slotFull[extVc] && ready;
    assign link.packet = slotData[extVc];

endmodule

// File: hdl/packetSlot.sv
`timescale 1ns/1ps

module packetSlot (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wrEnable,
    input  logic                  rdEnable,
    input  ringRouterPkg::packetT dataIn,
    output ringRouterPkg::packetT dataOut,
    output logic                  full,
    output logic                  empty
);

    logic                  valid;
    ringRouterPkg::packetT store;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (wrEnable) begin
            valid <= 1'b1;                // write wins, never paired with a read
        end else if (rdEnable) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEnable) begin
            store <= dataIn;
        end
    end

    assign dataOut = store;
    assign full    = valid;
    assign empty   = ~valid;

endmodule

// File: hdl/ringRouter.sv
`timescale 1ns/1ps

module ringRouter (
    input  logic                clk,
    input  logic                reset,
    output logic                polarity,
    input  ringRouterPkg::linkT cwIn,
    input  ringRouterPkg::linkT ccwIn,
    input  ringRouterPkg::linkT peIn,
    output logic                cwReady,
    output logic                ccwReady,
    output logic                peReady,
    output ringRouterPkg::linkT cwOut,
    output ringRouterPkg::linkT ccwOut,
    output ringRouterPkg::linkT peOut,
    input  logic                cwOutReady,
    input  logic                ccwOutReady,
    input  logic                peOutReady
);

    ringRouterPkg::packetT cwInPacket, ccwInPacket, peInPacket;
    ringRouterPkg::routeT  cwInRoute, ccwInRoute, peInRoute;
    logic                  cwInFull, ccwInFull, peInFull;
    logic                  cwInTake, ccwInTake, peInTake;

    ringRouterPkg::packetT cwOutPacket, ccwOutPacket, peOutPacket;
    logic                  cwOutEmpty, ccwOutEmpty, peOutEmpty;
    logic                  cwOutLoad, ccwOutLoad, peOutLoad;

    always_ff @(posedge clk) begin
        if (reset) begin
            polarity <= 1'b0;
        end else begin
            polarity <= ~polarity;        // swap external and fabric vc every cycle
        end
    end

    inputPort #(.isPePort(1'b0)) uCwIn (
        .clk(clk), .reset(reset), .polarity(polarity),
        .link(cwIn), .ready(cwReady),
        .take(cwInTake), .packet(cwInPacket), .full(cwInFull), .route(cwInRoute)
    );

    inputPort #(.isPePort(1'b0)) uCcwIn (
        .clk(clk), .reset(reset), .polarity(polarity),
        .link(ccwIn), .ready(ccwReady),
        .take(ccwInTake), .packet(ccwInPacket), .full(ccwInFull), .route(ccwInRoute)
    );

    inputPort #(.isPePort(1'b1)) uPeIn (
        .clk(clk), .reset(reset), .polarity(polarity),
        .link(peIn), .ready(peReady),
        .take(peInTake), .packet(peInPacket), .full(peInFull), .route(peInRoute)
    );

    switchFabric uFabric (
        .clk          (clk),
        .reset        (reset),
        .polarity     (polarity),
        .cwInPacket   (cwInPacket),
        .cwInFull     (cwInFull),
        .cwInRoute    (cwInRoute),
        .cwInTake     (cwInTake),
        .ccwInPacket  (ccwInPacket),
        .ccwInFull    (ccwInFull),
        .ccwInRoute   (ccwInRoute),
        .ccwInTake    (ccwInTake),
        .peInPacket   (peInPacket),
        .peInFull     (peInFull),
        .peInRoute    (peInRoute),
        .peInTake     (peInTake),
        .cwOutEmpty   (cwOutEmpty),
        .cwOutLoad    (cwOutLoad),
        .cwOutPacket  (cwOutPacket),
        .ccwOutEmpty  (ccwOutEmpty),
        .ccwOutLoad   (ccwOutLoad),
        .ccwOutPacket (ccwOutPacket),
        .peOutEmpty   (peOutEmpty),
        .peOutLoad    (peOutLoad),
        .peOutPacket  (peOutPacket)
    );

    outputPort uCwOut (
        .clk(clk), .reset(reset), .polarity(polarity),
        .load(cwOutLoad), .packet(cwOutPacket), .empty(cwOutEmpty),
        .ready(cwOutReady), .link(cwOut)
    );

    outputPort uCcwOut (
        .clk(clk), .reset(reset), .polarity(polarity),
        .load(ccwOutLoad), .packet(ccwOutPacket), .empty(ccwOutEmpty),
        .ready(ccwOutReady), .link(ccwOut)
    );

    outputPort uPeOut (
        .clk(clk), .reset(reset), .polarity(polarity),
        .load(peOutLoad), .packet(peOutPacket), .empty(peOutEmpty),
        .ready(peOutReady), .link(peOut)
    );

endmodule

// File: hdl/ringRouterPkg.sv
package ringRouterPkg;

    // two virtual channels, swapped between external and fabric side by polarity
    localparam int NUM_VC = 2;

    // hop counter position inside the 64-bit packet
    localparam int HOP_MSB = 55;
    localparam int HOP_LSB = 48;

    typedef struct packed {
        logic        vc;          // carried through unchanged
        logic        dir;         // 0 = inject clockwise, 1 = counter-clockwise
        logic [5:0]  reserved;
        logic [7:0]  hop;         // lsb set means keep travelling
        logic [47:0] payload;
    } packetT;

    // one channel between routers, send qualifies packet
    typedef struct packed {
        logic   send;
        packetT packet;
    } linkT;

    // request of an input port towards the fabric
    // for the pe input toRing means the ring direction picked by dir
    typedef struct packed {
        logic toRing;
        logic toPe;
    } routeT;

endpackage

// File: hdl/rotatingArbiter.sv
`timescale 1ns/1ps

module rotatingArbiter (
    input  logic clk,
    input  logic reset,
    input  logic polarity,
    input  logic req0,
    input  logic req1,
    output logic grant0,
    output logic grant1
);

    localparam int NUM_VC = ringRouterPkg::NUM_VC;

    logic [NUM_VC-1:0] favour1;           // per vc, 1 gives req1 the next conflict
    logic              conflict;
    logic              pickReq1;

    assign conflict = req0 && req1;
    assign pickReq1 = favour1[polarity];  // fabric serves the vc equal to polarity

    assign grant0 = req0 && (!req1 || !pickReq1);
    assign grant1 = req1 && (!req0 || pickReq1);

    // rotate only after a contested grant
    always_ff @(posedge clk) begin
        if (reset) begin
            favour1 <= '0;
        end else if (conflict) begin
            favour1[polarity] <= ~favour1[polarity];
        end
    end

endmodule

// File: hdl/switchFabric.sv
`timescale 1ns/1ps

module switchFabric (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  polarity,
    input  ringRouterPkg::packetT cwInPacket,
    input  logic                  cwInFull,
    input  ringRouterPkg::routeT  cwInRoute,
    output logic                  cwInTake,
    input  ringRouterPkg::packetT ccwInPacket,
    input  logic                  ccwInFull,
    input  ringRouterPkg::routeT  ccwInRoute,
    output logic                  ccwInTake,
    input  ringRouterPkg::packetT peInPacket,
    input  logic                  peInFull,
    input  ringRouterPkg::routeT  peInRoute,
    output logic                  peInTake,
    input  logic                  cwOutEmpty,
    output logic                  cwOutLoad,
    output ringRouterPkg::packetT cwOutPacket,
    input  logic                  ccwOutEmpty,
    output logic                  ccwOutLoad,
    output ringRouterPkg::packetT ccwOutPacket,
    input  logic                  peOutEmpty,
    output logic                  peOutLoad,
    output ringRouterPkg::packetT peOutPacket
);

    // one hop consumed per pass through the fabric
    function automatic ringRouterPkg::packetT hopShift(input ringRouterPkg::packetT p);
        ringRouterPkg::packetT q;
        q = p;
        q[ringRouterPkg::HOP_MSB:ringRouterPkg::HOP_LSB] =
            p[ringRouterPkg::HOP_MSB:ringRouterPkg::HOP_LSB] >> 1;
        return q;
    endfunction

    logic reqCwCw, reqCwPe;
    logic reqCcwCcw, reqCcwPe;
    logic reqPeCw, reqPeCcw;
    logic grantCwCw, grantCwPe;
    logic grantCcwCcw, grantCcwPe;
    logic grantPeCw, grantPeCcw;

    // a full target slot removes the request, so nothing is overwritten
    assign reqCwCw   = cwInFull && cwInRoute.toRing && cwOutEmpty;
    assign reqCwPe   = cwInFull && cwInRoute.toPe && peOutEmpty;
    assign reqCcwCcw = ccwInFull && ccwInRoute.toRing && ccwOutEmpty;
    assign reqCcwPe  = ccwInFull && ccwInRoute.toPe && peOutEmpty;
    assign reqPeCw   = peInFull && peInRoute.toRing && !peInPacket.dir && cwOutEmpty;
    assign reqPeCcw  = peInFull && peInRoute.toRing && peInPacket.dir && ccwOutEmpty;

    rotatingArbiter uCwArb (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .req0     (reqCwCw),
        .req1     (reqPeCw),
        .grant0   (grantCwCw),
        .grant1   (grantPeCw)
    );

    rotatingArbiter uCcwArb (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .req0     (reqCcwCcw),
        .req1     (reqPeCcw),
        .grant0   (grantCcwCcw),
        .grant1   (grantPeCcw)
    );

    rotatingArbiter uPeArb (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .req0     (reqCwPe),
        .req1     (reqCcwPe),
        .grant0   (grantCwPe),
        .grant1   (grantCcwPe)
    );

    assign cwInTake  = grantCwCw || grantCwPe;     // each input has only one route
    assign ccwInTake = grantCcwCcw || grantCcwPe;
    assign peInTake  = grantPeCw || grantPeCcw;

    assign cwOutLoad  = grantCwCw || grantPeCw;
    assign ccwOutLoad = grantCcwCcw || grantPeCcw;
    assign peOutLoad  = grantCwPe || grantCcwPe;

    assign cwOutPacket  = grantCwCw ? hopShift(cwInPacket) : hopShift(peInPacket);
    assign ccwOutPacket = grantCcwCcw ? hopShift(ccwInPacket) : hopShift(peInPacket);
    assign peOutPacket  = grantCwPe ? hopShift(cwInPacket) : hopShift(ccwInPacket);

endmodule

// File: run.sh
#!/bin/sh
# compile the ring router testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module ringRouterTb -o ringRouterSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/ringRouterSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi

// File: testbench/ringRouterTests.svh
function automatic logic randomBit();
    logic [31:0] r;
    r = $urandom();
    return r[0];
endfunction

function automatic logic [7:0] randomHop(input logic odd);
    logic [31:0] r;
    r = $urandom();
    return {r[7:1], odd};                     // lsb decides keep travelling or eject
endfunction

function automatic ringRouterPkg::packetT makePacket(input logic dir, input logic [7:0] hop);
    ringRouterPkg::packetT p;
    logic [63:0]           r;
    r = {$urandom(), $urandom()};
    p.vc       = r[63];
    p.dir      = dir;
    p.reserved = r[53:48];
    p.hop      = hop;
    p.payload  = r[47:0];
    return p;
endfunction

// where a packet entering on channel ch must leave
function automatic int targetPort(input int ch, input ringRouterPkg::packetT p);
    if (ch == PE) return p.dir ? CCW : CW;
    if (p.hop[0]) return ch;                  // ring packet keeps its direction
    return PE;
endfunction

function automatic ringRouterPkg::packetT afterHop(input ringRouterPkg::packetT p);
    ringRouterPkg::packetT q;
    q     = p;
    q.hop = {1'b0, p.hop[7:1]};               // one hop used up
    return q;
endfunction

function automatic string portName(input int port);
    case (port)
        CW:      return "cw";
        CCW:     return "ccw";
        default: return "pe";
    endcase
endfunction

function automatic logic inReady(input int ch);
    case (ch)
        CW:      return cwReady;
        CCW:     return ccwReady;
        default: return peReady;
    endcase
endfunction

task automatic driveLink(input int ch, input ringRouterPkg::linkT l);
    case (ch)
        CW:      cwIn = l;
        CCW:     ccwIn = l;
        default: peIn = l;
    endcase
endtask

task automatic checkBit(input string what, input logic exp, input logic act);
    assert (act === exp) else begin
        valueErrors++;
        $display("FAILED %s: %s expected %b actual %b", testName, what, exp, act);
    end
endtask

task automatic matchArrival(input int port, input ringRouterPkg::packetT got);
    int hit;
    hit = -1;
    assert (expected[port].size() != 0) else begin
        otherErrors++;
        $display("%s: packet %h left the %s output while none was expected",
                 testName, got, portName(port));
    end
    if (expected[port].size() != 0) begin
        for (int i = 0; i < expected[port].size(); i++) begin
            if (hit < 0 && expected[port][i] == got) hit = i;
        end
        assert (hit >= 0) else begin
            valueErrors++;
            $display("FAILED %s: %s output expected %h actual %h",
                     testName, portName(port), expected[port][0], got);
        end
        if (hit >= 0) expected[port].delete(hit);
    end
endtask

// holds send until a rising edge with ready high accepts the packet
task automatic sendPacket(input int ch, input ringRouterPkg::packetT p);
    ringRouterPkg::linkT l;
    l.send   = 1'b1;
    l.packet = p;
    @(negedge clk);
    driveLink(ch, l);
    while (!inReady(ch)) @(negedge clk);
    @(negedge clk);
    l.send = 1'b0;
    driveLink(ch, l);
endtask

task automatic injectPacket(input int ch, input ringRouterPkg::packetT p);
    expected[targetPort(ch, p)].push_back(afterHop(p));
    sendPacket(ch, p);
endtask

task automatic waitDrain();
    while (expected[CW].size() + expected[CCW].size() + expected[PE].size() != 0) begin
        @(negedge clk);
    end
endtask

task automatic resetState();
    logic expPol;
    testName = "reset";
    expPol   = 1'b0;                          // reset value of polarity
    #1;
    checkBit("polarity after reset", expPol, polarity);
    repeat (6) begin
        @(negedge clk);
        #1;
        expPol = ~expPol;                     // one toggle per cycle
        checkBit("polarity toggle", expPol, polarity);
        checkBit("cwReady", 1'b1, cwReady);
        checkBit("ccwReady", 1'b1, ccwReady);
        checkBit("peReady", 1'b1, peReady);
        checkBit("cwOut.send", 1'b0, cwOut.send);
        checkBit("ccwOut.send", 1'b0, ccwOut.send);
        checkBit("peOut.send", 1'b0, peOut.send);
    end
endtask

task automatic ringPassThrough();
    testName = "passThrough";
    fork
        repeat (3) injectPacket(CW, makePacket(randomBit(), randomHop(1'b1)));
        repeat (3) injectPacket(CCW, makePacket(randomBit(), randomHop(1'b1)));
    join
    waitDrain();
endtask

task automatic ejectToPe();
    testName = "ejection";
    fork                                      // both compete for the pe output
        repeat (3) injectPacket(CW, makePacket(randomBit(), randomHop(1'b0)));
        repeat (3) injectPacket(CCW, makePacket(randomBit(), randomHop(1'b0)));
    join
    waitDrain();
endtask

task automatic injectFromPe();
    testName = "injection";
    for (int k = 0; k < 4; k++) begin
        injectPacket(PE, makePacket(k[0], randomHop(randomBit())));
    end
    waitDrain();
endtask

task automatic backPressure();
    testName = "backPressure";
    @(negedge clk);
    cwOutReady = 1'b0;
    // both vc slots of the cw input and the cw output fill up
    repeat (4) injectPacket(CW, makePacket(randomBit(), randomHop(1'b1)));
    repeat (4) begin
        @(negedge clk);
        #1;
        checkBit("cwReady while blocked", 1'b0, cwReady);
        checkBit("cwOut.send while blocked", 1'b0, cwOut.send);
    end
    @(negedge clk);
    cwOutReady = 1'b1;
    waitDrain();
endtask

task automatic arbitrateContention();
    testName = "contention";
    repeat (3) begin
        fork
            injectPacket(CW, makePacket(randomBit(), randomHop(1'b1)));
            injectPacket(PE, makePacket(1'b0, randomHop(randomBit())));
        join
    end
    waitDrain();
endtask

// File: testbench/ringRouterTb.sv
`timescale 1ns/1ps

module ringRouterTb;

    localparam int RESET_CYCLES    = 10;
    localparam int NUM_TESTS       = 6;
    localparam int MAX_TEST_CYCLES = 150;
    // twice the longest possible test sequence, plus room for reset and drain
    localparam int TIMEOUT_CYCLES  = 2 * NUM_TESTS * MAX_TEST_CYCLES + 200;

    localparam int CW  = 0;                   // channel and output indices
    localparam int CCW = 1;
    localparam int PE  = 2;

    logic                clk;
    logic                reset;
    logic                polarity;
    ringRouterPkg::linkT cwIn, ccwIn, peIn;
    logic                cwReady, ccwReady, peReady;
    ringRouterPkg::linkT cwOut, ccwOut, peOut;
    logic                cwOutReady, ccwOutReady, peOutReady;

    ringRouterPkg::packetT expected [3][$];   // per output, packets still to arrive
    string                 testName;
    int                    valueErrors = 0;
    int                    otherErrors = 0;
    int                    cycles = 0;

    ringRouter u_dut (
        .clk         (clk),
        .reset       (reset),
        .polarity    (polarity),
        .cwIn        (cwIn),
        .ccwIn       (ccwIn),
        .peIn        (peIn),
        .cwReady     (cwReady),
        .ccwReady    (ccwReady),
        .peReady     (peReady),
        .cwOut       (cwOut),
        .ccwOut      (ccwOut),
        .peOut       (peOut),
        .cwOutReady  (cwOutReady),
        .ccwOutReady (ccwOutReady),
        .peOutReady  (peOutReady)
    );

    `include "ringRouterTests.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, test %s did not complete", cycles, testName);
            $display("errors: %0d value mismatches, %0d other failures",
                     valueErrors, otherErrors + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    // outputs settle shortly after the falling edge and hold until the rising one
    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (!reset) begin
                if (cwOut.send) matchArrival(CW, cwOut.packet);
                if (ccwOut.send) matchArrival(CCW, ccwOut.packet);
                if (peOut.send) matchArrival(PE, peOut.packet);
            end
        end
    end

    initial begin
        void'($urandom(32'h5eb98f69));
        reset       = 1'b1;
        cwIn        = '0;
        ccwIn       = '0;
        peIn        = '0;
        cwOutReady  = 1'b1;
        ccwOutReady = 1'b1;
        peOutReady  = 1'b1;
        testName    = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        resetState();
        ringPassThrough();
        ejectToPe();
        injectFromPe();
        backPressure();
        arbitrateContention();
        repeat (5) @(negedge clk);            // late duplicates still show up here

        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
